// File: Bender.yml
package:
  name: udp_merger

sources:
  - include_dirs:
      - common
    files:
      - common/packet_pkg.sv
      - common/merger_pkg.sv
      - logic/rr_arbiter.sv
      - logic/src_select.sv
      - udp_merger/merger_ctrl.sv
      - udp_merger/udp_merger.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/udp_merger_sva.sv
      - test/udp_merger_checker.sv
      - test/udp_merger_tb.sv

// File: common/merger_pkg.sv
`include "udp_merger_settings.svh"

package merger_pkg;

    // idle waits for a header, data forwards beats until last
    typedef enum logic {
        IDLE,
        DATA
    } merger_state_e;

    // one-hot over the default source count
    typedef logic [`UDP_MERGER_NUM_SRCS-1:0] grant_t;

endpackage

// File: common/packet_pkg.sv
package packet_pkg;

    // udp header as it sits on the wire, source port first
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] chksum;
    } udp_pkt_hdr;

    localparam int UDP_HDR_W = $bits(udp_pkt_hdr);

endpackage

// File: common/udp_merger_settings.svh
`ifndef UDP_MERGER_SETTINGS_SVH
`define UDP_MERGER_SETTINGS_SVH

// ipv4 address
`define IP_ADDR_W 32

// one mac beat
`define MAC_INTERFACE_W 64

// unused bytes in the final beat
`define MAC_PADBYTES_W 3

`define TIMESTAMP_W 64

// sources merged by default
`define UDP_MERGER_NUM_SRCS 3

`endif

// File: logic/rr_arbiter.sv
module rr_arbiter #(
     parameter int WIDTH = $bits(merger_pkg::grant_t)
)(
     input  logic               clk
    ,input  logic               rst

    ,input  logic [WIDTH-1:0]   reqs_i
    ,input  logic               yumi_i
    ,output logic [WIDTH-1:0]   grants_o
);

    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [IDX_W-1:0]   ptr_q;
    logic [IDX_W-1:0]   held_idx_q;
    logic               locked_q;
    logic [IDX_W-1:0]   pick_idx;
    logic               pick_val;
    logic [IDX_W-1:0]   cur_idx;

    // first requester at or after the pointer, wrapping around
    always_comb begin
        int unsigned idx;
        pick_idx = '0;
        pick_val = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            idx = (int'(ptr_q) + i) % WIDTH;
            if (reqs_i[idx]) begin
                pick_idx = IDX_W'(idx);
                pick_val = 1'b1;
            end
        end
    end

    // an offered grant stays put until the packet is done
    assign cur_idx = locked_q ? held_idx_q : pick_idx;

    always_comb begin
        grants_o = '0;
        if (locked_q || pick_val) begin
            grants_o[cur_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q      <= '0;
            held_idx_q <= '0;
            locked_q   <= 1'b0;
        end else if (yumi_i) begin
            locked_q <= 1'b0;
            ptr_q    <= (cur_idx == IDX_W'(WIDTH - 1)) ? '0 : cur_idx + 1'b1;
        end else if (!locked_q && pick_val) begin
            locked_q   <= 1'b1;
            held_idx_q <= pick_idx;
        end
    end

endmodule

// File: logic/src_select.sv
`include "udp_merger_settings.svh"

module src_select #(
     parameter int NUM_SRCS = $bits(merger_pkg::grant_t)
)(
     input  logic                                           clk
    ,input  logic                                           rst

    ,input  logic           [NUM_SRCS-1:0]                  grants_i
    ,input  logic                                           store_grant_i
    ,input  logic                                           in_packet_i

    ,input  logic           [NUM_SRCS-1:0]                  srcs_hdr_val_i
    ,input  logic           [NUM_SRCS-1:0][`IP_ADDR_W-1:0]  srcs_src_ip_i
    ,input  logic           [NUM_SRCS-1:0][`IP_ADDR_W-1:0]  srcs_dst_ip_i
    ,input  packet_pkg::udp_pkt_hdr [NUM_SRCS-1:0]          srcs_udp_hdr_i
    ,input  logic           [NUM_SRCS-1:0][`TIMESTAMP_W-1:0] srcs_timestamp_i
    ,input  logic           [NUM_SRCS-1:0]                  srcs_data_val_i
    ,input  logic [NUM_SRCS-1:0][`MAC_INTERFACE_W-1:0]      srcs_data_i
    ,input  logic           [NUM_SRCS-1:0]                  srcs_last_i
    ,input  logic [NUM_SRCS-1:0][`MAC_PADBYTES_W-1:0]       srcs_padbytes_i

    ,input  logic                                           ctrl_hdr_rdy_i
    ,input  logic                                           ctrl_data_rdy_i

    ,output logic           [`IP_ADDR_W-1:0]                dst_src_ip_o
    ,output logic           [`IP_ADDR_W-1:0]                dst_dst_ip_o
    ,output packet_pkg::udp_pkt_hdr                         dst_udp_hdr_o
    ,output logic           [`TIMESTAMP_W-1:0]              dst_timestamp_o
    ,output logic           [`MAC_INTERFACE_W-1:0]          dst_data_o
    ,output logic           [`MAC_PADBYTES_W-1:0]           dst_padbytes_o

    ,output logic                                           sel_hdr_val_o
    ,output logic                                           sel_data_val_o
    ,output logic                                           sel_last_o
    ,output logic           [NUM_SRCS-1:0]                  srcs_hdr_rdy_o
    ,output logic           [NUM_SRCS-1:0]                  srcs_data_rdy_o
);

    logic [NUM_SRCS-1:0]                grant_q;
    logic [NUM_SRCS-1:0]                sel;
    logic [packet_pkg::UDP_HDR_W-1:0]   udp_hdr_acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= '0;
        end else if (store_grant_i) begin
            grant_q <= grants_i;
        end
    end

    // live arbiter result between packets, held winner inside one
    assign sel = in_packet_i ? grant_q : grants_i;

    // and-or mux, sel is one-hot or empty
    always_comb begin
        dst_src_ip_o    = '0;
        dst_dst_ip_o    = '0;
        udp_hdr_acc     = '0;
        dst_timestamp_o = '0;
        dst_data_o      = '0;
        dst_padbytes_o  = '0;
        sel_hdr_val_o   = 1'b0;
        sel_data_val_o  = 1'b0;
        sel_last_o      = 1'b0;
        for (int i = 0; i < NUM_SRCS; i++) begin
            dst_src_ip_o    |= srcs_src_ip_i[i] & {`IP_ADDR_W{sel[i]}};
            dst_dst_ip_o    |= srcs_dst_ip_i[i] & {`IP_ADDR_W{sel[i]}};
            udp_hdr_acc     |= srcs_udp_hdr_i[i] & {packet_pkg::UDP_HDR_W{sel[i]}};
            dst_timestamp_o |= srcs_timestamp_i[i] & {`TIMESTAMP_W{sel[i]}};
            dst_data_o      |= srcs_data_i[i] & {`MAC_INTERFACE_W{sel[i]}};
            dst_padbytes_o  |= srcs_padbytes_i[i] & {`MAC_PADBYTES_W{sel[i]}};
            sel_hdr_val_o   |= srcs_hdr_val_i[i] & sel[i];
            sel_data_val_o  |= srcs_data_val_i[i] & sel[i];
            sel_last_o      |= srcs_last_i[i] & sel[i];
        end
    end

    assign dst_udp_hdr_o = udp_hdr_acc;

    // ready strobes only reach the selected source
    assign srcs_hdr_rdy_o  = sel & {NUM_SRCS{ctrl_hdr_rdy_i}};
    assign srcs_data_rdy_o = sel & {NUM_SRCS{ctrl_data_rdy_i}};

endmodule

// File: test/udp_merger_ref.svh
// tagged fields of packet n from source s
function automatic logic [`IP_ADDR_W-1:0] src_ip_of(input int s);
    return 32'hc0a80a00 | 32'(s[7:0]);
endfunction

function automatic logic [`IP_ADDR_W-1:0] dst_ip_of(input int s, input int n);
    return 32'h0a000000 | (32'(s) << 16) | 32'(n[15:0]);
endfunction

// beats in packet n from source s, one to six
function automatic int len_of(input int s, input int n);
    return 1 + ((s * 7 + n * 5 + (n >> 1)) % 6);
endfunction

function automatic packet_pkg::udp_pkt_hdr udp_hdr_of(input int s, input int n, input int len);
    packet_pkg::udp_pkt_hdr h;
    h.src_port = 16'h4000 + 16'(s);
    h.dst_port = 16'(n);
    h.length   = 16'(len);
    h.chksum   = 16'h0000;
    return h;
endfunction

function automatic logic [`TIMESTAMP_W-1:0] timestamp_of(input int s, input int n);
    return {32'(s) + 32'h1000, 32'(n) * 32'd977};
endfunction

function automatic logic [`MAC_INTERFACE_W-1:0] beat_data(input int s, input int n, input int b);
    return {8'(s), 8'(n), 8'(b), 8'h5a, 32'(s * 40503 + n * 2654 + b * 977)};
endfunction

// pad bytes in the last beat
function automatic logic [`MAC_PADBYTES_W-1:0] pad_of(input int n);
    return `MAC_PADBYTES_W'(n % 8);
endfunction

// File: test/udp_merger_checker.sv
`include "udp_merger_settings.svh"

module udp_merger_checker #(
     parameter int NUM_SRCS = `UDP_MERGER_NUM_SRCS
)(
     input  logic                           clk
    ,input  logic                           rst
    ,input  logic [NUM_SRCS-1:0]            srcs_hdr_val_i
    ,input  logic [NUM_SRCS-1:0]            srcs_hdr_rdy_i
    ,input  logic [NUM_SRCS-1:0]            srcs_data_rdy_i
    ,input  logic                           dst_hdr_val_i
    ,input  logic [`IP_ADDR_W-1:0]          dst_src_ip_i
    ,input  logic [`IP_ADDR_W-1:0]          dst_dst_ip_i
    ,input  packet_pkg::udp_pkt_hdr         dst_udp_hdr_i
    ,input  logic [`TIMESTAMP_W-1:0]        dst_timestamp_i
    ,input  logic                           dst_hdr_rdy_i
    ,input  logic                           dst_data_val_i
    ,input  logic [`MAC_INTERFACE_W-1:0]    dst_data_i
    ,input  logic                           dst_last_i
    ,input  logic [`MAC_PADBYTES_W-1:0]     dst_padbytes_i
    ,input  logic                           dst_data_rdy_i
    ,output int                             errors_o
    ,output int                             pkts_o
);

`include "udp_merger_ref.svh"

    int         exp_seq [NUM_SRCS];
    int         ptr;
    int         winner;
    bit         locked;
    bit         in_pkt;
    int         cur_src;
    int         cur_seq;
    int         cur_len;
    int         beat;
    bit         hdr_stall;
    bit         data_stall;
    logic [191:0] hdr_bus;
    logic [191:0] prev_hdr;
    logic [191:0] data_bus;
    logic [191:0] prev_data;

    initial begin
        errors_o = 0;
        pkts_o   = 0;
    end

    task automatic mismatch(input string name, input logic [191:0] got, input logic [191:0] exp);
        $display("** Error: %s is %0h, expected %0h at time %0t", name, got, exp, $time);
        errors_o++;
    endtask

    task automatic failure(input string what);
        $display("checker: %s at time %0t", what, $time);
        errors_o++;
    endtask

    function automatic int first_requester(input logic [NUM_SRCS-1:0] reqs, input int start);
        int idx;
        for (int i = 0; i < NUM_SRCS; i++) begin
            idx = (start + i) % NUM_SRCS;
            if (reqs[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic check_header();
        int s;
        packet_pkg::udp_pkt_hdr exp_hdr;
        s = int'(dst_src_ip_i[7:0]);
        if (in_pkt) begin
            failure("header transferred inside an open packet");
        end
        if (s >= NUM_SRCS) begin
            failure("header carries an unknown source index");
            return;
        end
        if (s != winner) begin
            mismatch("winning source", 192'(s), 192'(winner));
        end
        exp_hdr = udp_hdr_of(s, exp_seq[s], len_of(s, exp_seq[s]));
        if (dst_udp_hdr_i != exp_hdr) begin
            mismatch("dst_udp_hdr_o", 192'(dst_udp_hdr_i), 192'(exp_hdr));
        end
        if (dst_src_ip_i != src_ip_of(s)) begin
            mismatch("dst_src_ip_o", 192'(dst_src_ip_i), 192'(src_ip_of(s)));
        end
        if (dst_dst_ip_i != dst_ip_of(s, exp_seq[s])) begin
            mismatch("dst_dst_ip_o", 192'(dst_dst_ip_i), 192'(dst_ip_of(s, exp_seq[s])));
        end
        if (dst_timestamp_i != timestamp_of(s, exp_seq[s])) begin
            mismatch("dst_timestamp_o", 192'(dst_timestamp_i),
                     192'(timestamp_of(s, exp_seq[s])));
        end
        cur_src = s;
        cur_seq = exp_seq[s];
        cur_len = len_of(s, exp_seq[s]);
        beat    = 0;
        in_pkt  = 1'b1;
        exp_seq[s]++;
    endtask

    task automatic check_beat();
        logic exp_last;
        if (!in_pkt) begin
            failure("data beat outside a packet");
            return;
        end
        exp_last = (beat == cur_len - 1);
        if (dst_data_i != beat_data(cur_src, cur_seq, beat)) begin
            mismatch("dst_data_o", 192'(dst_data_i), 192'(beat_data(cur_src, cur_seq, beat)));
        end
        if (dst_last_i != exp_last) begin
            mismatch("dst_last_o", 192'(dst_last_i), 192'(exp_last));
        end
        if (dst_last_i && dst_padbytes_i != pad_of(cur_seq)) begin
            mismatch("dst_padbytes_o", 192'(dst_padbytes_i), 192'(pad_of(cur_seq)));
        end
        beat++;
        if (dst_last_i) begin
            in_pkt = 1'b0;
            locked = 1'b0;
            ptr    = (winner + 1) % NUM_SRCS;
            pkts_o++;
        end
    endtask

    // mid-cycle sampling, inputs and state are settled here
    always @(negedge clk) begin
        hdr_bus  = {dst_src_ip_i, dst_dst_ip_i, dst_udp_hdr_i, dst_timestamp_i};
        data_bus = 192'({dst_data_i, dst_last_i, dst_padbytes_i});
        if (rst) begin
            ptr        = 0;
            locked     = 1'b0;
            in_pkt     = 1'b0;
            hdr_stall  = 1'b0;
            data_stall = 1'b0;
            for (int i = 0; i < NUM_SRCS; i++) begin
                exp_seq[i] = 0;
            end
        end else begin
            if (hdr_stall && (!dst_hdr_val_i || hdr_bus != prev_hdr)) begin
                mismatch("stalled header", hdr_bus, prev_hdr);
            end
            if (data_stall && (!dst_data_val_i || data_bus != prev_data)) begin
                mismatch("stalled data beat", data_bus, prev_data);
            end
            if (!dst_hdr_rdy_i && srcs_hdr_rdy_i != '0) begin
                mismatch("srcs_hdr_rdy_o", 192'(srcs_hdr_rdy_i), 192'(0));
            end
            if (!dst_data_rdy_i && srcs_data_rdy_i != '0) begin
                mismatch("srcs_data_rdy_o", 192'(srcs_data_rdy_i), 192'(0));
            end
            // the winner is settled when the first request shows up
            if (!locked && srcs_hdr_val_i != '0) begin
                winner = first_requester(srcs_hdr_val_i, ptr);
                locked = 1'b1;
            end
            if (dst_hdr_val_i && dst_hdr_rdy_i) begin
                check_header();
            end
            if (dst_data_val_i && dst_data_rdy_i) begin
                check_beat();
            end
            hdr_stall  = dst_hdr_val_i && !dst_hdr_rdy_i;
            data_stall = dst_data_val_i && !dst_data_rdy_i;
            prev_hdr   = hdr_bus;
            prev_data  = data_bus;
        end
    end

endmodule

// File: test/udp_merger_sva.sv
module udp_merger_sva #(
     parameter int W = 1
)(
     input  logic           clk
    ,input  logic           rst
    ,input  logic           strobe_a_i
    ,input  logic           strobe_b_i
    ,input  logic [W-1:0]   sel_i
    ,input  logic [W-1:0]   rdy_i
);

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel_i))
        else $error("selection is not one-hot or zero");

    strobes_excl: assert property (@(posedge clk) disable iff (rst) !(strobe_a_i && strobe_b_i))
        else $error("exclusive strobes high together");

    rdy_single: assert property (@(posedge clk) disable iff (rst) $onehot0(rdy_i))
        else $error("more than one ready bit high");

endmodule

bind merger_ctrl udp_merger_sva #(.W(2)) ctrl_sva (
     .clk           (clk            )
    ,.rst           (rst            )
    ,.strobe_a_i    (store_grant_o  )
    ,.strobe_b_i    (advance_grant_o)
    ,.sel_i         ({dst_hdr_val_o, dst_data_val_o})
    ,.rdy_i         ({ctrl_hdr_rdy_o, ctrl_data_rdy_o})
);

bind src_select udp_merger_sva #(.W(NUM_SRCS)) select_sva (
     .clk           (clk                )
    ,.rst           (rst                )
    ,.strobe_a_i    (|srcs_hdr_rdy_o    )
    ,.strobe_b_i    (|srcs_data_rdy_o   )
    ,.sel_i         (sel                )
    ,.rdy_i         (srcs_hdr_rdy_o | srcs_data_rdy_o)
);

// File: test/udp_merger_tb.sv
`include "udp_merger_settings.svh"

module udp_merger_tb;

`include "udp_merger_ref.svh"

    localparam int NUM_SRCS = `UDP_MERGER_NUM_SRCS;
    localparam int PKTS     = 12;
    localparam int TOTAL    = NUM_SRCS * PKTS;
    localparam int PERIOD   = 40;
    localparam int TIMEOUT  = (TOTAL * 6 * 8 + 8) * PERIOD;

    logic                                           clk;
    logic                                           rst;
    logic [NUM_SRCS-1:0]                            srcs_hdr_val;
    logic [NUM_SRCS-1:0][`IP_ADDR_W-1:0]            srcs_src_ip;
    logic [NUM_SRCS-1:0][`IP_ADDR_W-1:0]            srcs_dst_ip;
    packet_pkg::udp_pkt_hdr [NUM_SRCS-1:0]          srcs_udp_hdr;
    logic [NUM_SRCS-1:0][`TIMESTAMP_W-1:0]          srcs_timestamp;
    logic [NUM_SRCS-1:0]                            srcs_hdr_rdy;
    logic [NUM_SRCS-1:0]                            srcs_data_val;
    logic [NUM_SRCS-1:0][`MAC_INTERFACE_W-1:0]      srcs_data;
    logic [NUM_SRCS-1:0]                            srcs_last;
    logic [NUM_SRCS-1:0][`MAC_PADBYTES_W-1:0]       srcs_padbytes;
    logic [NUM_SRCS-1:0]                            srcs_data_rdy;
    logic                                           dst_hdr_val;
    logic [`IP_ADDR_W-1:0]                          dst_src_ip;
    logic [`IP_ADDR_W-1:0]                          dst_dst_ip;
    packet_pkg::udp_pkt_hdr                         dst_udp_hdr;
    logic [`TIMESTAMP_W-1:0]                        dst_timestamp;
    logic                                           dst_hdr_rdy;
    logic                                           dst_data_val;
    logic [`MAC_INTERFACE_W-1:0]                    dst_data;
    logic                                           dst_last;
    logic [`MAC_PADBYTES_W-1:0]                     dst_padbytes;
    logic                                           dst_data_rdy;
    int                                             errors;
    int                                             pkts;
    integer                                         seed;

    udp_merger #(.NUM_SRCS(NUM_SRCS)) dut (.*,
        .srcs_hdr_val_i(srcs_hdr_val), .srcs_src_ip_i(srcs_src_ip),
        .srcs_dst_ip_i(srcs_dst_ip), .srcs_udp_hdr_i(srcs_udp_hdr),
        .srcs_timestamp_i(srcs_timestamp), .srcs_hdr_rdy_o(srcs_hdr_rdy),
        .srcs_data_val_i(srcs_data_val), .srcs_data_i(srcs_data), .srcs_last_i(srcs_last),
        .srcs_padbytes_i(srcs_padbytes), .srcs_data_rdy_o(srcs_data_rdy),
        .dst_hdr_val_o(dst_hdr_val), .dst_src_ip_o(dst_src_ip), .dst_dst_ip_o(dst_dst_ip),
        .dst_udp_hdr_o(dst_udp_hdr), .dst_timestamp_o(dst_timestamp),
        .dst_hdr_rdy_i(dst_hdr_rdy), .dst_data_val_o(dst_data_val), .dst_data_o(dst_data),
        .dst_last_o(dst_last), .dst_padbytes_o(dst_padbytes), .dst_data_rdy_i(dst_data_rdy));

    udp_merger_checker #(.NUM_SRCS(NUM_SRCS)) chk (.clk, .rst,
        .srcs_hdr_val_i(srcs_hdr_val), .srcs_hdr_rdy_i(srcs_hdr_rdy),
        .srcs_data_rdy_i(srcs_data_rdy), .dst_hdr_val_i(dst_hdr_val),
        .dst_src_ip_i(dst_src_ip), .dst_dst_ip_i(dst_dst_ip), .dst_udp_hdr_i(dst_udp_hdr),
        .dst_timestamp_i(dst_timestamp), .dst_hdr_rdy_i(dst_hdr_rdy),
        .dst_data_val_i(dst_data_val), .dst_data_i(dst_data), .dst_last_i(dst_last),
        .dst_padbytes_i(dst_padbytes), .dst_data_rdy_i(dst_data_rdy),
        .errors_o(errors), .pkts_o(pkts));

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // ready seen mid-cycle means the transfer happens on the next edge
    task automatic wait_ready(input int s, input bit is_data);
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = is_data ? srcs_data_rdy[s] : srcs_hdr_rdy[s];
        end
        next_cycle();
    endtask

    task automatic send_packets(input int s);
        int len;
        int gap;
        for (int n = 0; n < PKTS; n++) begin
            gap = ($random(seed) & 32'h7fffffff) % 4;
            repeat (gap) next_cycle();
            len = len_of(s, n);
            srcs_src_ip[s]    = src_ip_of(s);
            srcs_dst_ip[s]    = dst_ip_of(s, n);
            srcs_udp_hdr[s]   = udp_hdr_of(s, n, len);
            srcs_timestamp[s] = timestamp_of(s, n);
            srcs_hdr_val[s]   = 1'b1;
            wait_ready(s, 1'b0);
            srcs_hdr_val[s] = 1'b0;
            for (int b = 0; b < len; b++) begin
                srcs_data[s]     = beat_data(s, n, b);
                srcs_last[s]     = (b == len - 1);
                srcs_padbytes[s] = (b == len - 1) ? pad_of(n) : '0;
                srcs_data_val[s] = 1'b1;
                wait_ready(s, 1'b1);
            end
            srcs_data_val[s] = 1'b0;
            srcs_last[s]     = 1'b0;
        end
    endtask

    initial begin
        seed           = 1996;
        rst            = 1'b1;
        srcs_hdr_val   = '0;
        srcs_src_ip    = '0;
        srcs_dst_ip    = '0;
        srcs_udp_hdr   = '0;
        srcs_timestamp = '0;
        srcs_data_val  = '0;
        srcs_data      = '0;
        srcs_last      = '0;
        srcs_padbytes  = '0;
        dst_hdr_rdy    = 1'b0;
        dst_data_rdy   = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        fork
            send_packets(0);
            send_packets(1);
            send_packets(2);
        join
        wait (pkts == TOTAL);
        repeat (2) next_cycle();
        $display("errors: %0d, packets checked: %0d of %0d", errors, pkts, TOTAL);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // random back-pressure on both destination channels
    initial begin
        forever begin
            next_cycle();
            dst_hdr_rdy  = $random(seed);
            dst_data_rdy = $random(seed);
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired with %0d of %0d packets received", pkts, TOTAL);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: udp_merger/merger_ctrl.sv
module merger_ctrl (
     input  logic   clk
    ,input  logic   rst

    ,input  logic   sel_hdr_val_i
    ,input  logic   sel_data_val_i
    ,input  logic   sel_last_i

    ,input  logic   dst_hdr_rdy_i
    ,input  logic   dst_data_rdy_i

    ,output logic   dst_hdr_val_o
    ,output logic   dst_data_val_o
    ,output logic   ctrl_hdr_rdy_o
    ,output logic   ctrl_data_rdy_o

    ,output logic   store_grant_o
    ,output logic   advance_grant_o
    ,output logic   in_packet_o
);

    merger_pkg::merger_state_e state_q;
    merger_pkg::merger_state_e state_d;

    logic in_idle;
    logic hdr_xfer;
    logic last_xfer;

    assign in_idle = (state_q == merger_pkg::IDLE);

    // headers only pass in idle, beats only in data
    assign dst_hdr_val_o   = in_idle & sel_hdr_val_i;
    assign ctrl_hdr_rdy_o  = in_idle & dst_hdr_rdy_i;
    assign dst_data_val_o  = ~in_idle & sel_data_val_i;
    assign ctrl_data_rdy_o = ~in_idle & dst_data_rdy_i;

    assign hdr_xfer  = dst_hdr_val_o & dst_hdr_rdy_i;
    assign last_xfer = dst_data_val_o & dst_data_rdy_i & sel_last_i;

    // latch the winner when its header goes out
    assign store_grant_o   = hdr_xfer;
    // release the arbiter on the final beat
    assign advance_grant_o = last_xfer;
    assign in_packet_o     = ~in_idle;

    always_comb begin
        state_d = state_q;
        case (state_q)
            merger_pkg::IDLE: begin
                if (hdr_xfer) begin
                    state_d = merger_pkg::DATA;
                end
            end
            merger_pkg::DATA: begin
                if (last_xfer) begin
                    state_d = merger_pkg::IDLE;
                end
            end
            default: begin
                state_d = merger_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= merger_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: udp_merger/udp_merger.sv
`include "udp_merger_settings.svh"

module udp_merger #(
     parameter int NUM_SRCS = `UDP_MERGER_NUM_SRCS
)(
     input  logic                                           clk
    ,input  logic                                           rst

    ,input  logic           [NUM_SRCS-1:0]                  srcs_hdr_val_i
    ,input  logic           [NUM_SRCS-1:0][`IP_ADDR_W-1:0]  srcs_src_ip_i
    ,input  logic           [NUM_SRCS-1:0][`IP_ADDR_W-1:0]  srcs_dst_ip_i
    ,input  packet_pkg::udp_pkt_hdr [NUM_SRCS-1:0]          srcs_udp_hdr_i
    ,input  logic           [NUM_SRCS-1:0][`TIMESTAMP_W-1:0] srcs_timestamp_i
    ,output logic           [NUM_SRCS-1:0]                  srcs_hdr_rdy_o

    ,input  logic           [NUM_SRCS-1:0]                  srcs_data_val_i
    ,input  logic [NUM_SRCS-1:0][`MAC_INTERFACE_W-1:0]      srcs_data_i
    ,input  logic           [NUM_SRCS-1:0]                  srcs_last_i
    ,input  logic [NUM_SRCS-1:0][`MAC_PADBYTES_W-1:0]       srcs_padbytes_i
    ,output logic           [NUM_SRCS-1:0]                  srcs_data_rdy_o

    ,output logic                                           dst_hdr_val_o
    ,output logic           [`IP_ADDR_W-1:0]                dst_src_ip_o
    ,output logic           [`IP_ADDR_W-1:0]                dst_dst_ip_o
    ,output packet_pkg::udp_pkt_hdr                         dst_udp_hdr_o
    ,output logic           [`TIMESTAMP_W-1:0]              dst_timestamp_o
    ,input  logic                                           dst_hdr_rdy_i

    ,output logic                                           dst_data_val_o
    ,output logic           [`MAC_INTERFACE_W-1:0]          dst_data_o
    ,output logic                                           dst_last_o
    ,output logic           [`MAC_PADBYTES_W-1:0]           dst_padbytes_o
    ,input  logic                                           dst_data_rdy_i
);

    logic [NUM_SRCS-1:0]    grants;
    logic                   store_grant;
    logic                   advance_grant;
    logic                   in_packet;
    logic                   sel_hdr_val;
    logic                   sel_data_val;
    logic                   ctrl_hdr_rdy;
    logic                   ctrl_data_rdy;

    rr_arbiter #(
         .WIDTH     (NUM_SRCS       )
    ) arbiter (
         .clk       (clk            )
        ,.rst       (rst            )
        ,.reqs_i    (srcs_hdr_val_i )
        ,.yumi_i    (advance_grant  )
        ,.grants_o  (grants         )
    );

    src_select #(
         .NUM_SRCS          (NUM_SRCS           )
    ) select (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.grants_i          (grants             )
        ,.store_grant_i     (store_grant        )
        ,.in_packet_i       (in_packet          )
        ,.srcs_hdr_val_i    (srcs_hdr_val_i     )
        ,.srcs_src_ip_i     (srcs_src_ip_i      )
        ,.srcs_dst_ip_i     (srcs_dst_ip_i      )
        ,.srcs_udp_hdr_i    (srcs_udp_hdr_i     )
        ,.srcs_timestamp_i  (srcs_timestamp_i   )
        ,.srcs_data_val_i   (srcs_data_val_i    )
        ,.srcs_data_i       (srcs_data_i        )
        ,.srcs_last_i       (srcs_last_i        )
        ,.srcs_padbytes_i   (srcs_padbytes_i    )
        ,.ctrl_hdr_rdy_i    (ctrl_hdr_rdy       )
        ,.ctrl_data_rdy_i   (ctrl_data_rdy      )
        ,.dst_src_ip_o      (dst_src_ip_o       )
        ,.dst_dst_ip_o      (dst_dst_ip_o       )
        ,.dst_udp_hdr_o     (dst_udp_hdr_o      )
        ,.dst_timestamp_o   (dst_timestamp_o    )
        ,.dst_data_o        (dst_data_o         )
        ,.dst_padbytes_o    (dst_padbytes_o     )
        ,.sel_hdr_val_o     (sel_hdr_val        )
        ,.sel_data_val_o    (sel_data_val       )
        ,.sel_last_o        (dst_last_o         )
        ,.srcs_hdr_rdy_o    (srcs_hdr_rdy_o     )
        ,.srcs_data_rdy_o   (srcs_data_rdy_o    )
    );

    merger_ctrl ctrl (
         .clk               (clk            )
        ,.rst               (rst            )
        ,.sel_hdr_val_i     (sel_hdr_val    )
        ,.sel_data_val_i    (sel_data_val   )
        ,.sel_last_i        (dst_last_o     )
        ,.dst_hdr_rdy_i     (dst_hdr_rdy_i  )
        ,.dst_data_rdy_i    (dst_data_rdy_i )
        ,.dst_hdr_val_o     (dst_hdr_val_o  )
        ,.dst_data_val_o    (dst_data_val_o )
        ,.ctrl_hdr_rdy_o    (ctrl_hdr_rdy   )
        ,.ctrl_data_rdy_o   (ctrl_data_rdy  )
        ,.store_grant_o     (store_grant    )
        ,.advance_grant_o   (advance_grant  )
        ,.in_packet_o       (in_packet      )
    );

endmodule

// File: vlog.f
+incdir+common
+incdir+test
common/packet_pkg.sv
common/merger_pkg.sv
logic/rr_arbiter.sv
logic/src_select.sv
udp_merger/merger_ctrl.sv
udp_merger/udp_merger.sv
test/udp_merger_sva.sv
test/udp_merger_checker.sv
test/udp_merger_tb.sv
